/* hw/ifetch_pkg.sv */
`default_nettype none

package ifetch_pkg;

  // address split for a 16M byte instruction space
  localparam int XLEN             = 32;
  localparam int CACHE_LEN        = 7;
  localparam int LINE_LEN         = 4;
  localparam int LINE_BITS        = 3;
  localparam int UNUSED_ADDR_BITS = 8;
  localparam int TAG_WIDTH        = 18;

  // byte address of the interrupt and trap vector table
  localparam logic [XLEN-1:0] VTABLE_BASE = 32'h0000_0400;

  // master to slave, adr is a word address
  typedef struct packed {
    logic            cyc;
    logic            stb;
    logic [XLEN-3:0] adr;
    logic [3:0]      sel;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic            ack;
    logic [XLEN-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {FILL_IDLE, FILL_ARB, FILL_READ, FILL_DONE} fill_state_e;

  typedef enum logic [1:0] {VEC_IDLE, VEC_ARB, VEC_READ, VEC_DONE} vec_state_e;

  typedef enum logic [1:0] {OWNER_NONE, OWNER_FILL, OWNER_VEC} bus_owner_e;

endpackage

`default_nettype wire

/* hw/bram_dual.sv */
`timescale 1ns/1ps
`default_nettype none

module bram_dual #(
  parameter int addr_width_p = 7,
  parameter int data_width_p = 32
) (
  input  logic                    clk_i,
  input  logic                    write_i,
  input  logic [addr_width_p-1:0] waddr_i,
  input  logic [data_width_p-1:0] data_i,
  input  logic [addr_width_p-1:0] raddr_i,
  output logic [data_width_p-1:0] data_o
);

  logic [data_width_p-1:0] mem [2**addr_width_p];

  always_ff @(posedge clk_i) begin
    if (write_i) begin
      mem[waddr_i] <= data_i;
    end
  end

  // registered read, one cycle latency
  always_ff @(posedge clk_i) begin
    data_o <= mem[raddr_i];
  end

endmodule

`default_nettype wire

/* hw/instruction_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module instruction_cache (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_i,
  input  logic [ifetch_pkg::XLEN-1:0] addr_i,
  output logic                        busy_o,
  output logic [ifetch_pkg::XLEN-1:0] instr_o,
  output logic                        instr_valid_o,
  output logic                        req_o,
  input  logic                        grant_i,
  output ifetch_pkg::wb_req_t         wb_o,
  input  ifetch_pkg::wb_rsp_t         wb_i
);

  import ifetch_pkg::*;

  fill_state_e              fill_state;
  logic [TAG_WIDTH-1:0]     tags [2**LINE_BITS];
  logic [2**LINE_BITS-1:0]  tag_valid;
  logic [2**LINE_BITS-1:0]  tag_match;
  logic [LINE_BITS-1:0]     hit_line;
  logic [LINE_BITS-1:0]     repl_ptr;
  logic                     hit;
  logic [TAG_WIDTH-1:0]     addr_tag;
  logic [TAG_WIDTH-1:0]     fill_tag;
  logic [LINE_LEN-1:0]      word_idx;
  logic                     ram_write;

  assign addr_tag = addr_i[XLEN-1-UNUSED_ADDR_BITS -: TAG_WIDTH];

  // parallel tag compare over all lines
  always_comb begin
    tag_match = '0;
    hit_line  = '0;
    for (int i = 0; i < 2**LINE_BITS; i++) begin
      tag_match[i] = tag_valid[i] && (tags[i] == addr_tag);
      if (tag_match[i]) begin
        hit_line = LINE_BITS'(i);
      end
    end
  end

  assign hit = |tag_match;

  assign busy_o    = (fill_state != FILL_IDLE);
  assign req_o     = (fill_state == FILL_ARB) || (fill_state == FILL_READ);
  assign ram_write = (fill_state == FILL_READ) && wb_i.ack;

  // stb stays high across the whole line, adr steps on each ack
  assign wb_o = '{
    cyc: (fill_state == FILL_READ),
    stb: (fill_state == FILL_READ),
    adr: {{UNUSED_ADDR_BITS{1'b0}}, fill_tag, word_idx},
    sel: 4'hF
  };

  bram_dual #(
    .addr_width_p(CACHE_LEN),
    .data_width_p(XLEN)
  ) data_ram (
    .clk_i  (clk_i),
    .write_i(ram_write),
    .waddr_i({repl_ptr, word_idx}),
    .data_i (wb_i.dat),
    .raddr_i({hit_line, addr_i[LINE_LEN+1:2]}),
    .data_o (instr_o)
  );

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fill_state    <= FILL_IDLE;
      tag_valid     <= '0;
      repl_ptr      <= '0;
      word_idx      <= '0;
      instr_valid_o <= 1'b0;
    end else begin
      // data_o follows the read issued at this edge
      instr_valid_o <= fetch_i && hit && (fill_state == FILL_IDLE);
      case (fill_state)
        FILL_IDLE: begin
          if (fetch_i && !hit) begin
            // victim line is invalid while it is being refilled
            tag_valid[repl_ptr] <= 1'b0;
            word_idx            <= '0;
            fill_state          <= FILL_ARB;
          end
        end
        FILL_ARB: begin
          if (grant_i) begin
            fill_state <= FILL_READ;
          end
        end
        FILL_READ: begin
          if (wb_i.ack) begin
            word_idx <= word_idx + 1'b1;
            if (word_idx == '1) begin
              fill_state <= FILL_DONE;
            end
          end
        end
        FILL_DONE: begin
          tag_valid[repl_ptr] <= 1'b1;
          repl_ptr            <= repl_ptr + 1'b1;
          fill_state          <= FILL_IDLE;
        end
        default: fill_state <= FILL_IDLE;
      endcase
    end
  end

  // tag payload, qualified by tag_valid
  always_ff @(posedge clk_i) begin
    if (fill_state == FILL_IDLE && fetch_i && !hit) begin
      fill_tag <= addr_tag;
    end
    if (fill_state == FILL_DONE) begin
      tags[repl_ptr] <= fill_tag;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    fetch_i |-> addr_i[1:0] == 2'b00)
    else $error("misaligned fetch address %h", addr_i);

  // the arbiter grant must cover every strobe we drive
  assert property (@(posedge clk_i) disable iff (reset_i)
    wb_o.stb |-> grant_i)
    else $error("fill strobe without bus grant");

  assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(tag_match))
    else $error("multiple tags match %h", addr_tag);

endmodule

`default_nettype wire

/* hw/vector_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module vector_fetch (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        vector_req_i,
  input  logic [ifetch_pkg::XLEN-1:0] vector_offset_i,
  output logic                        vector_busy_o,
  output logic [ifetch_pkg::XLEN-1:0] vector_pc_o,
  output logic                        vector_valid_o,
  output logic                        req_o,
  input  logic                        grant_i,
  output ifetch_pkg::wb_req_t         wb_o,
  input  ifetch_pkg::wb_rsp_t         wb_i
);

  import ifetch_pkg::*;

  vec_state_e       vec_state;
  logic [XLEN-1:0]  vec_byte_addr;
  logic [XLEN-3:0]  vec_adr;

  // table entry address in bytes
  assign vec_byte_addr = VTABLE_BASE + vector_offset_i;

  assign req_o          = (vec_state == VEC_ARB) || (vec_state == VEC_READ);
  assign vector_busy_o  = req_o;
  assign vector_valid_o = (vec_state == VEC_DONE);

  assign wb_o = '{
    cyc: (vec_state == VEC_READ),
    stb: (vec_state == VEC_READ),
    adr: vec_adr,
    sel: 4'hF
  };

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      vec_state <= VEC_IDLE;
    end else begin
      case (vec_state)
        // a new request may follow the valid pulse directly
        VEC_IDLE, VEC_DONE: begin
          if (vector_req_i) begin
            vec_adr   <= vec_byte_addr[XLEN-1:2];
            vec_state <= VEC_ARB;
          end else begin
            vec_state <= VEC_IDLE;
          end
        end
        VEC_ARB: begin
          if (grant_i) begin
            vec_state <= VEC_READ;
          end
        end
        VEC_READ: begin
          if (wb_i.ack) begin
            vector_pc_o <= wb_i.dat;
            vec_state   <= VEC_DONE;
          end
        end
        default: vec_state <= VEC_IDLE;
      endcase
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    vector_req_i |-> !vector_busy_o)
    else $error("vector request while a lookup is in progress");

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                fill_req_i,
  input  logic                vec_req_i,
  output logic                fill_grant_o,
  output logic                vec_grant_o,
  input  ifetch_pkg::wb_req_t fill_wb_i,
  input  ifetch_pkg::wb_req_t vec_wb_i,
  output ifetch_pkg::wb_rsp_t fill_wb_o,
  output ifetch_pkg::wb_rsp_t vec_wb_o,
  output ifetch_pkg::wb_req_t wb_o,
  input  ifetch_pkg::wb_rsp_t wb_i
);

  import ifetch_pkg::*;

  bus_owner_e owner;

  // owner locks until its requester lets go, vector wins a tie
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner <= OWNER_NONE;
    end else begin
      case (owner)
        OWNER_NONE: begin
          if (vec_req_i) begin
            owner <= OWNER_VEC;
          end else if (fill_req_i) begin
            owner <= OWNER_FILL;
          end
        end
        OWNER_FILL: if (!fill_req_i) owner <= OWNER_NONE;
        OWNER_VEC:  if (!vec_req_i) owner <= OWNER_NONE;
        default:    owner <= OWNER_NONE;
      endcase
    end
  end

  assign fill_grant_o = (owner == OWNER_FILL);
  assign vec_grant_o  = (owner == OWNER_VEC);

  // idle bus keeps cyc and stb low
  always_comb begin
    wb_o      = '0;
    fill_wb_o = '0;
    vec_wb_o  = '0;
    case (owner)
      OWNER_FILL: begin
        wb_o      = fill_wb_i;
        fill_wb_o = wb_i;
      end
      OWNER_VEC: begin
        wb_o     = vec_wb_i;
        vec_wb_o = wb_i;
      end
      default: ;
    endcase
  end

  // the owner lets go of the bus only between transfers
  assert property (@(posedge clk_i) disable iff (reset_i)
    ((fill_grant_o && !fill_req_i) || (vec_grant_o && !vec_req_i)) |-> !wb_o.cyc)
    else $error("bus released with a cycle in flight");

endmodule

`default_nettype wire

/* hw/ifetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module ifetch_top (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        fetch_i,
  input  logic [ifetch_pkg::XLEN-1:0] addr_i,
  output logic                        busy_o,
  output logic [ifetch_pkg::XLEN-1:0] instr_o,
  output logic                        instr_valid_o,
  input  logic                        vector_req_i,
  input  logic [ifetch_pkg::XLEN-1:0] vector_offset_i,
  output logic                        vector_busy_o,
  output logic [ifetch_pkg::XLEN-1:0] vector_pc_o,
  output logic                        vector_valid_o,
  output ifetch_pkg::wb_req_t         wb_o,
  input  ifetch_pkg::wb_rsp_t         wb_i
);

  import ifetch_pkg::*;

  logic    fill_req;
  logic    fill_grant;
  logic    vec_req;
  logic    vec_grant;
  wb_req_t fill_wb_req;
  wb_rsp_t fill_wb_rsp;
  wb_req_t vec_wb_req;
  wb_rsp_t vec_wb_rsp;

  instruction_cache icache (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .fetch_i      (fetch_i),
    .addr_i       (addr_i),
    .busy_o       (busy_o),
    .instr_o      (instr_o),
    .instr_valid_o(instr_valid_o),
    .req_o        (fill_req),
    .grant_i      (fill_grant),
    .wb_o         (fill_wb_req),
    .wb_i         (fill_wb_rsp)
  );

  vector_fetch vfetch (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .vector_req_i   (vector_req_i),
    .vector_offset_i(vector_offset_i),
    .vector_busy_o  (vector_busy_o),
    .vector_pc_o    (vector_pc_o),
    .vector_valid_o (vector_valid_o),
    .req_o          (vec_req),
    .grant_i        (vec_grant),
    .wb_o           (vec_wb_req),
    .wb_i           (vec_wb_rsp)
  );

  // single master port shared by fill and vector engines
  bus_arbiter arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .fill_req_i  (fill_req),
    .vec_req_i   (vec_req),
    .fill_grant_o(fill_grant),
    .vec_grant_o (vec_grant),
    .fill_wb_i   (fill_wb_req),
    .vec_wb_i    (vec_wb_req),
    .fill_wb_o   (fill_wb_rsp),
    .vec_wb_o    (vec_wb_rsp),
    .wb_o        (wb_o),
    .wb_i        (wb_i)
  );

endmodule

`default_nettype wire

/* testbench/tb_wb_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_wb_memory (
  input  logic                clk_i,
  input  logic                reset_i,
  input  ifetch_pkg::wb_req_t wb_i,
  output ifetch_pkg::wb_rsp_t wb_o
);

  import ifetch_pkg::*;

  integer          seed = 32'h9715;
  logic [1:0]      wait_cnt;
  logic [XLEN-1:0] byte_addr;

  assign byte_addr = {wb_i.adr, 2'b00};

  // registered ack, wait states picked ahead of each transfer
  always @(posedge clk_i) begin
    if (reset_i) begin
      wb_o.ack <= 1'b0;
      wb_o.dat <= '0;
      wait_cnt <= 2'($random(seed));
    end else begin
      wb_o.ack <= 1'b0;
      if (wb_i.cyc && wb_i.stb && !wb_o.ack) begin
        if (wait_cnt == 2'd0) begin
          wb_o.ack <= 1'b1;
          wb_o.dat <= 32'hC0DE_0000 ^ byte_addr;
          wait_cnt <= 2'($random(seed));
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/tb_ifetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ifetch;

  import ifetch_pkg::*;

  localparam int TIMEOUT_CYCLES = 500;

  logic            clk;
  logic            reset;
  logic            fetch;
  logic [XLEN-1:0] addr;
  logic            busy;
  logic [XLEN-1:0] instr;
  logic            instr_valid;
  logic            vector_req;
  logic [XLEN-1:0] vector_offset;
  logic            vector_busy;
  logic [XLEN-1:0] vector_pc;
  logic            vector_valid;
  wb_req_t         wb_req;
  wb_rsp_t         wb_rsp;

  // bus monitor record, one entry per acked read
  logic [XLEN-3:0] xfer_adr [$];
  int              xfer_burst [$];
  int              burst_id = 0;
  int              cyc_cycles = 0;
  logic            cyc_q = 1'b0;

  ifetch_top dut (
    .clk_i          (clk),
    .reset_i        (reset),
    .fetch_i        (fetch),
    .addr_i         (addr),
    .busy_o         (busy),
    .instr_o        (instr),
    .instr_valid_o  (instr_valid),
    .vector_req_i   (vector_req),
    .vector_offset_i(vector_offset),
    .vector_busy_o  (vector_busy),
    .vector_pc_o    (vector_pc),
    .vector_valid_o (vector_valid),
    .wb_o           (wb_req),
    .wb_i           (wb_rsp)
  );

  tb_wb_memory memory (
    .clk_i  (clk),
    .reset_i(reset),
    .wb_i   (wb_req),
    .wb_o   (wb_rsp)
  );

  always #50 clk = ~clk;

  // a new burst starts at each rise of cyc
  always @(posedge clk) begin
    if (wb_req.cyc && !cyc_q) begin
      burst_id++;
    end
    cyc_q = wb_req.cyc;
    if (wb_req.cyc) begin
      cyc_cycles++;
    end
    // every read selects all four bytes
    if (wb_req.cyc && wb_req.stb) begin
      check_word("wb_o.sel", 32'(wb_req.sel), 32'h0000_000F);
    end
    if (wb_req.cyc && wb_req.stb && wb_rsp.ack) begin
      xfer_adr.push_back(wb_req.adr);
      xfer_burst.push_back(burst_id);
    end
  end

  function automatic logic [XLEN-1:0] expected_word(input logic [XLEN-1:0] byte_addr);
    return 32'hC0DE_0000 ^ byte_addr;
  endfunction

  function automatic logic in_vector_table(input logic [XLEN-3:0] word_adr);
    logic [XLEN-1:0] byte_addr;
    byte_addr = {word_adr, 2'b00};
    return (byte_addr >= VTABLE_BASE) && (byte_addr < VTABLE_BASE + 32'h40);
  endfunction

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_on_error($sformatf("[FAIL] %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_idle();
    check_bit("busy_o", busy, 1'b0);
    check_bit("instr_valid_o", instr_valid, 1'b0);
    check_bit("vector_busy_o", vector_busy, 1'b0);
    check_bit("vector_valid_o", vector_valid, 1'b0);
    check_bit("wb_o.cyc", wb_req.cyc, 1'b0);
    check_bit("wb_o.stb", wb_req.stb, 1'b0);
  endtask

  task automatic reset_test();
    for (int i = 0; i < 16; i++) begin
      @(negedge clk);
      check_idle();
    end
    reset = 1'b0;
    repeat (2) begin
      @(negedge clk);
      check_idle();
    end
  endtask

  // the 16 reads since start must walk the line of a from word 0
  task automatic check_line_reads(input int start, input logic [XLEN-1:0] a);
    check_word("fill read count", 32'(xfer_adr.size() - start), 32'd16);
    for (int k = 0; k < 16; k++) begin
      check_word("fill read address", {xfer_adr[start+k], 2'b00},
                 {a[XLEN-1:6], 6'b0} + 32'(k * 4));
    end
  endtask

  task automatic fetch_miss_test(input logic [XLEN-1:0] a);
    int start;
    int cycles;
    start = xfer_adr.size();
    @(negedge clk);
    fetch = 1'b1;
    addr  = a;
    @(negedge clk);
    check_bit("busy_o after miss", busy, 1'b1);
    check_bit("instr_valid_o during miss", instr_valid, 1'b0);
    cycles = 0;
    while (!instr_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for instr_valid_o after a cache miss");
      end
    end
    check_word("instr_o", instr, expected_word(a));
    check_bit("busy_o at instr_valid_o", busy, 1'b0);
    fetch = 1'b0;
    check_line_reads(start, a);
  endtask

  task automatic check_hit_result(input logic [XLEN-1:0] a);
    check_bit("instr_valid_o on hit", instr_valid, 1'b1);
    check_bit("busy_o on hit", busy, 1'b0);
    check_word("instr_o", instr, expected_word(a));
  endtask

  task automatic fetch_hit_test(input logic [XLEN-1:0] a);
    int cyc_before;
    cyc_before = cyc_cycles;
    @(negedge clk);
    fetch = 1'b1;
    addr  = a;
    @(negedge clk);
    check_hit_result(a);
    fetch = 1'b0;
    check_word("bus cycles during hit", 32'(cyc_cycles - cyc_before), 32'd0);
  endtask

  // one new address per cycle, result of the previous one checked first
  task automatic line_hits_test(input logic [XLEN-1:0] base);
    int cyc_before;
    cyc_before = cyc_cycles;
    for (int k = 0; k < 16; k++) begin
      @(negedge clk);
      if (k > 0) begin
        check_hit_result(base + 32'((k - 1) * 4));
      end
      fetch = 1'b1;
      addr  = base + 32'(k * 4);
    end
    @(negedge clk);
    check_hit_result(base + 32'd60);
    fetch = 1'b0;
    check_word("bus cycles during line hits", 32'(cyc_cycles - cyc_before), 32'd0);
  endtask

  task automatic round_robin_test(input logic [XLEN-1:0] first_line);
    for (int k = 1; k <= 8; k++) begin
      fetch_miss_test(32'h0000_3000 + 32'(k * 256));
    end
    // first line was evicted by the eighth fill, its refill takes the next slot
    fetch_miss_test(first_line);
    fetch_hit_test(32'h0000_3800 + 32'd8);
    fetch_hit_test(32'h0000_3200 + 32'd36);
  endtask

  task automatic vector_test(input logic [XLEN-1:0] offset);
    int start;
    int cycles;
    start = xfer_adr.size();
    @(negedge clk);
    vector_req    = 1'b1;
    vector_offset = offset;
    @(negedge clk);
    vector_req = 1'b0;
    check_bit("vector_busy_o after request", vector_busy, 1'b1);
    cycles = 0;
    while (!vector_valid) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for vector_valid_o");
      end
    end
    check_word("vector_pc_o", vector_pc, expected_word(VTABLE_BASE + offset));
    check_bit("vector_busy_o at vector_valid_o", vector_busy, 1'b0);
    check_word("vector read count", 32'(xfer_adr.size() - start), 32'd1);
    check_word("vector read address", {xfer_adr[start], 2'b00}, VTABLE_BASE + offset);
    @(negedge clk);
    check_bit("vector_valid_o after pulse", vector_valid, 1'b0);
  endtask

  // reads of one cyc burst must all come from the same engine
  task automatic check_ownership(input int start, input logic [XLEN-1:0] a,
                                 input logic [XLEN-1:0] offset);
    int fill_k;
    int vec_n;
    fill_k = 0;
    vec_n  = 0;
    for (int i = start; i < xfer_adr.size(); i++) begin
      if (i > start && xfer_burst[i] == xfer_burst[i-1] &&
          in_vector_table(xfer_adr[i]) != in_vector_table(xfer_adr[i-1])) begin
        stop_on_error("fill and vector reads interleaved within one bus ownership");
      end
      if (in_vector_table(xfer_adr[i])) begin
        check_word("vector read address", {xfer_adr[i], 2'b00}, VTABLE_BASE + offset);
        vec_n++;
      end else begin
        check_word("fill read address", {xfer_adr[i], 2'b00},
                   {a[XLEN-1:6], 6'b0} + 32'(fill_k * 4));
        fill_k++;
      end
    end
    check_word("fill read count", 32'(fill_k), 32'd16);
    check_word("vector read count", 32'(vec_n), 32'd1);
  endtask

  task automatic contention_test(input logic [XLEN-1:0] a, input logic [XLEN-1:0] offset,
                                 input int delay);
    int   start;
    int   cycles;
    logic instr_done;
    logic vec_done;
    start      = xfer_adr.size();
    cycles     = 0;
    instr_done = 1'b0;
    vec_done   = 1'b0;
    @(negedge clk);
    fetch = 1'b1;
    addr  = a;
    if (delay == 0) begin
      vector_req    = 1'b1;
      vector_offset = offset;
    end
    while (!(instr_done && vec_done)) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        stop_on_error("timed out waiting for fill and vector fetch to both finish");
      end
      vector_req = 1'b0;
      if (cycles == delay) begin
        check_bit("wb_o.cyc of fill at vector request", wb_req.cyc, 1'b1);
        vector_req    = 1'b1;
        vector_offset = offset;
      end
      if (fetch && instr_valid) begin
        check_word("instr_o", instr, expected_word(a));
        fetch      = 1'b0;
        instr_done = 1'b1;
      end
      if (vector_valid) begin
        check_word("vector_pc_o", vector_pc, expected_word(VTABLE_BASE + offset));
        vec_done = 1'b1;
      end
    end
    check_ownership(start, a, offset);
    // vector has priority when both ask in the same cycle
    if (delay == 0) begin
      check_bit("vector read first", in_vector_table(xfer_adr[start]), 1'b1);
    end
  endtask

  initial begin
    clk           = 1'b0;
    reset         = 1'b1;
    fetch         = 1'b0;
    addr          = '0;
    vector_req    = 1'b0;
    vector_offset = '0;
    reset_test();
    fetch_miss_test(32'h0000_1014);
    line_hits_test(32'h0000_1000);
    round_robin_test(32'h0000_1000);
    vector_test(32'h0000_0000);
    vector_test(32'h0000_0004);
    vector_test(32'h0000_0020);
    vector_test(32'h0000_003C);
    contention_test(32'h0005_0024, 32'h0000_0010, 3);
    contention_test(32'h0005_0048, 32'h0000_002C, 0);
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
hw/ifetch_pkg.sv
hw/bram_dual.sv
hw/instruction_cache.sv
hw/vector_fetch.sv
hw/bus_arbiter.sv
hw/ifetch_top.sv
testbench/tb_wb_memory.sv
testbench/tb_ifetch.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f compile.f --top-module tb_ifetch -o sim_ifetch \
  && ./obj_dir/sim_ifetch | tee /dev/stderr | grep -q "Verification passed" \
  && echo "run_sim: PASS" \
  || { echo "run_sim: FAIL"; exit 1; }
